// File: source/memCtrl_settings.svh
`ifndef MEM_CTRL_SETTINGS_SVH
`define MEM_CTRL_SETTINGS_SVH

// address bus to the RAM
`define MEM_ADDR_WIDTH 32

// word seen by the processor side
`define MEM_WORD_WIDTH 32

// the RAM is byte wide
`define MEM_BYTE_WIDTH 8

// instruction fetch always reads a full word
`define MEM_FETCH_BYTES 4

`endif

// File: source/memPkg.sv
`include "memCtrl_settings.svh"

package memPkg;

    // access currently walked on the RAM port
    typedef enum logic [1:0] {
        accIdle,
        accFetch,
        accLoad,
        accStore
    } accessT;

    // who holds the memory port
    typedef enum logic [1:0] {
        ownFree  = 2'b00,
        ownData  = 2'b01,
        ownFetch = 2'b10
    } ownerT;

    typedef logic [`MEM_WORD_WIDTH-1:0] wordT;
    // access length in bytes, 1, 2 or 4
    typedef logic [2:0] lenT;
    typedef logic [`MEM_BYTE_WIDTH-1:0] byteT;

endpackage

// File: source/memArbiter.sv
`timescale 1ns/10ps
`include "memCtrl_settings.svh"

module memArbiter (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            dataEn,
    input  logic            dataStore,
    input  memPkg::lenT     dataLen,
    input  memPkg::wordT    dataAddr,
    input  memPkg::wordT    dataWr,
    input  logic            fetchEn,
    input  memPkg::wordT    fetchAddr,
    input  logic            finish,
    output logic            start,
    output memPkg::accessT  access,
    output memPkg::wordT    baseAddr,
    output memPkg::wordT    storeWord,
    output memPkg::lenT     len,
    output memPkg::ownerT   owner
);
    logic busy;
    // one dead cycle after each access so the requester can drop its enable
    logic cool;

    always_ff @(posedge clk) begin
        if (rst) begin
            start    <= 1'b0;
            busy     <= 1'b0;
            cool     <= 1'b0;
            access   <= memPkg::accIdle;
            owner    <= memPkg::ownFree;
            baseAddr <= '0;
        end else if (!stall) begin
            start <= 1'b0;
            if (busy) begin
                if (finish) begin
                    busy   <= 1'b0;
                    cool   <= 1'b1;
                    access <= memPkg::accIdle;
                    owner  <= memPkg::ownFree;
                end
            end else if (cool) begin
                cool <= 1'b0;
            end else if (dataEn) begin
                // data side wins a collision
                busy     <= 1'b1;
                start    <= 1'b1;
                access   <= dataStore ? memPkg::accStore : memPkg::accLoad;
                owner    <= memPkg::ownData;
                baseAddr <= dataAddr;
            end else if (fetchEn) begin
                busy     <= 1'b1;
                start    <= 1'b1;
                access   <= memPkg::accFetch;
                owner    <= memPkg::ownFetch;
                baseAddr <= fetchAddr;
            end
        end
    end

    // request operands
    always_ff @(posedge clk) begin
        if (!stall && !busy && !cool) begin
            if (dataEn) begin
                storeWord <= dataWr;
                len       <= dataLen;
            end else if (fetchEn) begin
                len <= memPkg::lenT'(`MEM_FETCH_BYTES);
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (busy && (access == memPkg::accLoad || access == memPkg::accStore))
        |-> len inside {3'd1, 3'd2, 3'd4});

endmodule

// File: source/byteSequencer.sv
`timescale 1ns/10ps
`include "memCtrl_settings.svh"

module byteSequencer (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            start,
    input  memPkg::accessT  access,
    input  memPkg::wordT    baseAddr,
    input  memPkg::wordT    storeWord,
    input  memPkg::lenT     len,
    output logic            memWe,
    output memPkg::wordT    memAddr,
    output memPkg::byteT    memWr,
    output logic            capture,
    output logic            last,
    output memPkg::lenT     index,
    output logic            finish
);
    logic         busy;
    memPkg::lenT  count;
    memPkg::lenT  cur;
    logic         issue;
    logic         lastNow;
    logic         isRead;
    logic         isStore;
    // read side runs one cycle behind the address
    logic         capDly;
    logic         lastDly;
    memPkg::lenT  indexDly;

    assign isRead  = (access == memPkg::accLoad) || (access == memPkg::accFetch);
    assign isStore = (access == memPkg::accStore);

    // byte 0 goes out in the start cycle itself
    assign issue   = start || busy;
    assign cur     = start ? '0 : count;
    assign lastNow = issue && (cur == len - 3'd1);

    assign memAddr = baseAddr + `MEM_ADDR_WIDTH'(cur);
    assign memWe   = issue && isStore && !stall;
    assign memWr   = (issue && isStore) ?
                     storeWord[cur[1:0] * `MEM_BYTE_WIDTH +: `MEM_BYTE_WIDTH] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            count    <= '0;
            capDly   <= 1'b0;
            lastDly  <= 1'b0;
            indexDly <= '0;
        end else if (!stall) begin
            capDly   <= issue && isRead;
            lastDly  <= lastNow && isRead;
            indexDly <= cur;
            if (issue) begin
                if (lastNow) begin
                    busy  <= 1'b0;
                    count <= '0;
                end else begin
                    busy  <= 1'b1;
                    count <= cur + 3'd1;
                end
            end
        end
    end

    // stores complete with the last write, reads when the last byte returns
    assign capture = isRead ? capDly : (issue && isStore);
    assign last    = isRead ? lastDly : lastNow;
    assign index   = isRead ? indexDly : cur;
    assign finish  = (isRead ? (capDly && lastDly) : (isStore && lastNow)) && !stall;

    assert property (@(posedge clk) disable iff (rst)
        busy |-> (count != '0) && (count < len));

    // no write strobe from the start of a read until it completes
    assert property (@(posedge clk) disable iff (rst)
        (start && isRead && !stall) |-> !memWe until_with finish);

endmodule

// File: source/wordAssembler.sv
`timescale 1ns/10ps
`include "memCtrl_settings.svh"

module wordAssembler (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            capture,
    input  logic            last,
    input  memPkg::lenT     index,
    input  memPkg::accessT  access,
    input  memPkg::byteT    memRd,
    output logic            dataDone,
    output memPkg::wordT    dataRd,
    output logic            fetchDone,
    output memPkg::wordT    fetchInst
);
    memPkg::wordT  buffer;
    memPkg::wordT  baseWord;
    memPkg::wordT  assembled;
    memPkg::wordT  dataReg;
    memPkg::wordT  instReg;
    logic          capValid;
    logic          isRead;
    logic          loadHit;
    logic          fetchHit;
    logic          storeHit;

    assign capValid = capture && !stall;
    assign isRead   = (access == memPkg::accLoad) || (access == memPkg::accFetch);

    // start from zero at byte 0 so short loads come out zero-extended
    assign baseWord  = (index == '0) ? '0 : buffer;
    assign assembled = baseWord |
                       (memPkg::wordT'(memRd) << (index[1:0] * `MEM_BYTE_WIDTH));

    assign loadHit  = capValid && last && (access == memPkg::accLoad);
    assign fetchHit = capValid && last && (access == memPkg::accFetch);
    assign storeHit = capValid && last && (access == memPkg::accStore);

    always_ff @(posedge clk) begin
        if (capValid && isRead) begin
            buffer <= assembled;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dataReg <= '0;
            instReg <= '0;
        end else begin
            if (loadHit) begin
                dataReg <= assembled;
            end
            if (fetchHit) begin
                instReg <= assembled;
            end
        end
    end

    // the finished word bypasses the register in its done cycle
    assign dataDone  = loadHit || storeHit;
    assign dataRd    = loadHit ? assembled : dataReg;
    assign fetchDone = fetchHit;
    assign fetchInst = fetchHit ? assembled : instReg;

    assert property (@(posedge clk) disable iff (rst) !(dataDone && fetchDone));

endmodule

// File: source/memCtrl.sv
`timescale 1ns/10ps

module memCtrl (
    input  logic            clk,
    input  logic            rst,
    input  logic            rdy,
    input  logic            ioBufferFull,
    input  logic            dataEn,
    input  logic            dataStore,
    input  memPkg::lenT     dataLen,
    input  memPkg::wordT    dataAddr,
    input  memPkg::wordT    dataWr,
    input  logic            fetchEn,
    input  memPkg::wordT    fetchAddr,
    input  memPkg::byteT    memRd,
    output logic            memWe,
    output memPkg::wordT    memAddr,
    output memPkg::byteT    memWr,
    output logic            dataDone,
    output memPkg::wordT    dataRd,
    output logic            fetchDone,
    output memPkg::wordT    fetchInst,
    output memPkg::ownerT   owner
);
    logic            stall;
    logic            start;
    logic            finish;
    memPkg::accessT  access;
    memPkg::wordT    baseAddr;
    memPkg::wordT    storeWord;
    memPkg::lenT     len;
    logic            capture;
    logic            last;
    memPkg::lenT     index;

    // whole controller freezes on either condition
    assign stall = !rdy || ioBufferFull;

    memArbiter i_arbiter (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .dataEn    (dataEn),
        .dataStore (dataStore),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWr    (dataWr),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .finish    (finish),
        .start     (start),
        .access    (access),
        .baseAddr  (baseAddr),
        .storeWord (storeWord),
        .len       (len),
        .owner     (owner)
    );

    byteSequencer i_sequencer (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .start     (start),
        .access    (access),
        .baseAddr  (baseAddr),
        .storeWord (storeWord),
        .len       (len),
        .memWe     (memWe),
        .memAddr   (memAddr),
        .memWr     (memWr),
        .capture   (capture),
        .last      (last),
        .index     (index),
        .finish    (finish)
    );

    wordAssembler i_assembler (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .capture   (capture),
        .last      (last),
        .index     (index),
        .access    (access),
        .memRd     (memRd),
        .dataDone  (dataDone),
        .dataRd    (dataRd),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst)
    );

endmodule

// File: verification/memCtrlTb.sv
`timescale 1ns/10ps
`include "memCtrl_settings.svh"

module memCtrlTb;
    localparam int maxTests    = 64;
    // random stall cycles allowed per test line
    localparam int stallBudget = 30;

    logic           clk, rst, rdy, ioBufferFull;
    logic           dataEn, dataStore, fetchEn;
    memPkg::lenT    dataLen;
    memPkg::wordT   dataAddr, dataWr, fetchAddr;
    memPkg::byteT   memRd, memWr;
    logic           memWe, dataDone, fetchDone;
    memPkg::wordT   memAddr, dataRd, fetchInst;
    memPkg::ownerT  owner;

    memPkg::byteT   ram [0:65535];
    // eight words per test line
    memPkg::wordT   tests [0:maxTests*8-1];
    int             numTests = 0;
    logic           loaded = 1'b0;
    logic           stallMode;
    logic           stalled;
    int             stallsLeft;
    int unsigned    seedValue;
    int             wordErrors = 0;
    int             byteErrors = 0;
    int             ownerErrors = 0;
    int             flagErrors = 0;
    int             otherErrors = 0;

    memCtrl i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // byte pattern mixes both address bytes
    initial begin
        memRd = '0;
        for (int a = 0; a < 65536; a++) begin
            ram[a] = memPkg::byteT'(a[7:0] ^ a[15:8]);
        end
    end

    // synchronous RAM, frozen together with the controller
    always @(posedge clk) begin
        if (rdy && !ioBufferFull) begin
            if (memWe) begin
                ram[memAddr[15:0]] <= memWr;
            end
            memRd <= ram[memAddr[15:0]];
        end
    end

    task automatic checkWord(input string name, input memPkg::wordT exp,
                             input memPkg::wordT act);
        if (act !== exp) begin
            wordErrors++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkByte(input string name, input memPkg::byteT exp,
                             input memPkg::byteT act);
        if (act !== exp) begin
            byteErrors++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkOwner(input string name, input memPkg::ownerT exp,
                              input memPkg::ownerT act);
        if (act !== exp) begin
            ownerErrors++;
            $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flagErrors++;
            $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic printCounts();
        $display("error counts: word %0d, byte %0d, owner %0d, strobe %0d, other %0d",
                 wordErrors, byteErrors, ownerErrors, flagErrors, otherErrors);
    endtask

    // next falling edge, maybe a stall cycle
    task automatic fallEdge();
        @(negedge clk);
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        if (stallMode && stallsLeft > 0 && ($urandom % 4) == 0) begin
            stallsLeft--;
            if ($urandom % 2) begin
                rdy = 1'b0;
            end else begin
                ioBufferFull = 1'b1;
            end
        end
        stalled = !rdy || ioBufferFull;
    endtask

    task automatic advance();
        fallEdge();
        #1;
    endtask

    // pos counts non-stall cycles, 0 is the cycle the arbiter takes the request
    task automatic awaitDone(input logic isData, input logic isStore,
                             input memPkg::wordT addr, input int n,
                             input memPkg::wordT storeWord,
                             input memPkg::wordT expWord);
        int             pos;
        int             doneAt;
        logic           doneSeen;
        logic           granted;
        memPkg::ownerT  who;
        pos      = -1;
        doneAt   = isStore ? n : n + 1;
        doneSeen = 1'b0;
        who      = isData ? memPkg::ownData : memPkg::ownFetch;
        while (!doneSeen) begin
            if (!stalled) begin
                pos++;
            end
            granted = pos > 0 || (stalled && pos == 0);
            checkOwner("owner", granted ? who : memPkg::ownFree, owner);
            checkFlag("memWe", isStore && !stalled && pos >= 1 && pos <= n, memWe);
            if (!stalled && pos >= 1 && pos <= n) begin
                checkWord("memAddr", addr + pos - 1, memAddr);
                if (isStore) begin
                    checkByte("memWr",
                              memPkg::byteT'(storeWord >> (`MEM_BYTE_WIDTH * (pos - 1))),
                              memWr);
                end
            end
            doneSeen = !stalled && pos == doneAt;
            checkFlag("dataDone", isData && doneSeen, dataDone);
            checkFlag("fetchDone", !isData && doneSeen, fetchDone);
            if (doneSeen && !isStore) begin
                checkWord(isData ? "dataRd" : "fetchInst", expWord,
                          isData ? dataRd : fetchInst);
            end
            if (!doneSeen) begin
                advance();
            end
        end
        fallEdge();
        if (isData) begin
            dataEn = 1'b0;
        end else begin
            fetchEn = 1'b0;
        end
        #1;
        checkOwner("owner", memPkg::ownFree, owner);
        // arbiter needs one non-stall idle cycle
        while (stalled) begin
            advance();
            checkOwner("owner", memPkg::ownFree, owner);
        end
    endtask

    task automatic runTest(input int base);
        int op;
        op         = tests[base];
        stallMode  = tests[base + 1][0];
        stallsLeft = stallBudget;
        fallEdge();
        if (op != 0) begin
            dataEn    = 1'b1;
            dataStore = (op == 2);
            dataAddr  = tests[base + 2];
            dataLen   = memPkg::lenT'(tests[base + 3]);
            dataWr    = tests[base + 4];
        end
        if (op == 0 || op == 3) begin
            fetchEn   = 1'b1;
            fetchAddr = (op == 0) ? tests[base + 2] : tests[base + 6];
        end
        #1;
        if (op != 0) begin
            awaitDone(1'b1, op == 2, tests[base + 2], tests[base + 3],
                      tests[base + 4], tests[base + 5]);
        end
        if (op == 3) begin
            advance();
        end
        if (op == 0 || op == 3) begin
            awaitDone(1'b0, 1'b0, fetchAddr, `MEM_FETCH_BYTES, '0,
                      (op == 0) ? tests[base + 5] : tests[base + 7]);
        end
    endtask

    initial begin
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        dataEn       = 1'b0;
        dataStore    = 1'b0;
        dataLen      = '0;
        dataAddr     = '0;
        dataWr       = '0;
        fetchEn      = 1'b0;
        fetchAddr    = '0;
        stallMode    = 1'b0;
        stalled      = 1'b0;
        stallsLeft   = 0;
        seedValue    = $urandom(32'h1e9a_9b88);
        foreach (tests[k]) begin
            tests[k] = '1;
        end
        $readmemh("verification/memCtrl_tests.txt", tests);
        while (numTests < maxTests && tests[numTests * 8] !== '1) begin
            numTests++;
        end
        loaded = 1'b1;
        if (numTests == 0) begin
            otherErrors++;
            $display("no test lines found in the data file");
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;
        #1;
        checkOwner("owner", memPkg::ownFree, owner);
        checkFlag("memWe", 1'b0, memWe);
        checkFlag("dataDone", 1'b0, dataDone);
        checkFlag("fetchDone", 1'b0, fetchDone);
        checkWord("memAddr", '0, memAddr);
        checkWord("dataRd", '0, dataRd);
        checkWord("fetchInst", '0, fetchInst);
        for (int i = 0; i < numTests; i++) begin
            runTest(i * 8);
        end
        printCounts();
        if (wordErrors + byteErrors + ownerErrors + flagErrors + otherErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // ten cycles per line plus the stall budget
    initial begin
        wait (loaded);
        repeat (8 + numTests * (10 + stallBudget)) @(posedge clk);
        otherErrors++;
        $display("run timed out before all test lines completed");
        printCounts();
        $display("Test failures found");
        $finish;
    end

endmodule

// File: list.f
+incdir+source
source/memPkg.sv
source/memArbiter.sv
source/byteSequencer.sv
source/wordAssembler.sv
source/memCtrl.sv
verification/memCtrlTb.sv

// File: verification/memCtrl_tests.txt
// op mode addr len storeWord expectedWord fetchAddr expectedInst
// op 0 fetch, 1 load, 2 store, 3 load colliding with fetch; mode 1 adds random stalls
0 0 00000000 0 00000000 03020100 00000000 00000000
0 0 00001234 0 00000000 25242726 00000000 00000000
2 0 00000100 4 deadbeef 00000000 00000000 00000000
1 0 00000100 4 00000000 deadbeef 00000000 00000000
2 0 00000200 2 1234cafe 00000000 00000000 00000000
1 0 00000200 4 00000000 0100cafe 00000000 00000000
1 0 00000200 2 00000000 0000cafe 00000000 00000000
2 0 00000300 1 aabbcc5a 00000000 00000000 00000000
1 0 00000300 1 00000000 0000005a 00000000 00000000
1 0 00000300 4 00000000 0001025a 00000000 00000000
0 0 00000100 0 00000000 deadbeef 00000000 00000000
3 0 00000100 4 00000000 deadbeef 00001234 25242726
1 0 00000101 2 00000000 0000adbe 00000000 00000000
1 0 00000203 1 00000000 00000001 00000000 00000000
// same kinds of access with the controller stalled at random
2 1 00004000 4 76543210 00000000 00000000 00000000
1 1 00004000 4 00000000 76543210 00000000 00000000
2 1 00004100 2 0000a55a 00000000 00000000 00000000
1 1 00004100 2 00000000 0000a55a 00000000 00000000
2 1 00004200 1 ffffff81 00000000 00000000 00000000
1 1 00004200 1 00000000 00000081 00000000 00000000
0 1 0000abcd 0 00000000 7b646566 00000000 00000000
3 1 00004000 4 00000000 76543210 00000200 0100cafe
0 1 0000fffc 0 00000000 00010203 00000000 00000000
1 1 00001234 4 00000000 25242726 00000000 00000000
3 1 00000300 1 00000000 0000005a 0000abcd 7b646566
